/* src.f */
+incdir+rtl
rtl/router_pkg.sv
rtl/router_fifo.sv
rtl/router_apb_cmd.sv
rtl/router_channel_source.sv
rtl/router_lane_arbiter.sv
rtl/router_lane_crossbar.sv
rtl/router_channel_top.sv
bench/router_clkgen.sv
bench/router_chk.sv
bench/router_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module router_tb -f src.f -o router_sim \
    && ./obj_dir/router_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

/* bench/router_tb.sv */
`timescale 1ns/100ps
`include "router_consts.svh"

module router_tb;

    localparam int NS = `ROUTER_SOURCES;
    localparam int NK = `ROUTER_SINKS;
    localparam int DW = `ROUTER_DATA;

    logic clk;
    logic rst;
    logic psel;
    logic penable;
    logic pwrite;
    logic [7:0] paddr;
    logic [31:0] pwdata;
    logic pready;
    logic [31:0] prdata;
    logic pslverr;
    logic [NS-1:0] source_valid;
    logic [NS-1:0] source_ready;
    router_pkg::beat_t source_beat [NS];
    logic [NK-1:0] sink_valid;
    router_pkg::beat_t sink_beat [NK];
    logic [NK-1:0] sink_ready;

    logic [DW:0] tx_q [NS][$];   // {last, data} not yet taken by the source
    logic [DW:0] exp_q [NS][$];  // beats still owed to some sink
    int cmd_q [NS][$];           // destination sink per packet, in command order
    logic [NS-1:0] fire;
    logic [NK-1:0] stalled;
    router_pkg::beat_t held [NK];
    int pkt_src [NK];            // source mid-packet at a sink, -1 when idle
    integer seed;
    int errors;
    int test_errs;
    int tests;
    int tests_failed;
    int cycles;
    int total_beats;
    logic backpressure;

    router_clkgen u_clkgen (.clk(clk), .rst(rst));

    router_channel_top dut (.*);

    task automatic apb_start(input int src, input int sink);
        @(posedge clk);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = 8'(src * 4);
        pwdata = 32'(sink);
        @(posedge clk);
        #1;
        penable = 1'b1;
    endtask

    task automatic apb_finish(input int src, input int sink);
        @(negedge clk);
        while (!pready) @(negedge clk);
        if (pslverr !== 1'b0) begin
            $display("** Error: pslverr = %h, expected 0", pslverr);
            errors++;
        end
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        cmd_q[src].push_back(sink);
    endtask

    // one full APB transfer that must not touch any command FIFO
    task automatic apb_probe(input logic [7:0] addr, input logic write);
        @(posedge clk);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = 32'h3;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) @(negedge clk);
        if (pslverr !== 1'b0) begin
            $display("** Error: pslverr = %h, expected 0", pslverr);
            errors++;
        end
        if (!write && prdata !== 32'h0) begin
            $display("** Error: prdata = %h, expected 0", prdata);
            errors++;
        end
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic add_packet(input int src);
        int len;
        logic [DW:0] beat;
        len = 1 + ($unsigned($random(seed)) % 6);
        for (int i = 0; i < len; i++) begin
            beat = {i == len - 1, DW'($random(seed))};
            tx_q[src].push_back(beat);
            exp_q[src].push_back(beat);
        end
        total_beats += len;
    endtask

    task automatic random_traffic(input int packets);
        int s;
        int k;
        repeat (packets) begin
            s = $unsigned($random(seed)) % NS;
            k = $unsigned($random(seed)) % NK;
            apb_start(s, k);
            apb_finish(s, k);
            add_packet(s);
        end
    endtask

    task automatic wait_drain();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = 1'b0;
            for (int s = 0; s < NS; s++) begin
                if (tx_q[s].size() != 0 || exp_q[s].size() != 0) begin
                    busy = 1'b1;
                end
            end
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic check_beat(input int k);
        int s;
        logic [DW:0] want;
        s = int'(sink_beat[k].src);
        if (pkt_src[k] >= 0 && pkt_src[k] != s) begin
            $display("** Error: sink_beat[%0d].src = %h, expected %h", k, s, pkt_src[k]);
            errors++;
        end
        if (exp_q[s].size() == 0 || cmd_q[s].size() == 0) begin
            $display("sink %0d got a beat from source %0d with nothing pending", k, s);
            errors++;
            return;
        end
        if (cmd_q[s][0] != k) begin
            $display("** Error: sink_valid index = %h, expected %h for source %h",
                     k, cmd_q[s][0], s);
            errors++;
        end
        want = exp_q[s].pop_front();
        if ({sink_beat[k].last, sink_beat[k].data} != want) begin
            $display("** Error: sink_beat[%0d] {last,data} = %h, expected %h",
                     k, {sink_beat[k].last, sink_beat[k].data}, want);
            errors++;
        end
        pkt_src[k] = want[DW] ? -1 : s;
        if (want[DW]) begin
            void'(cmd_q[s].pop_front());
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors != test_errs) begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", name, errors - test_errs);
        end else begin
            $display("test %s: ok", name);
        end
        test_errs = errors;
    endtask

    // source and sink side drive, 1 ns after the edge
    always @(posedge clk) begin
        #1;
        for (int s = 0; s < NS; s++) begin
            if (fire[s]) begin
                void'(tx_q[s].pop_front());
            end
            source_valid[s] = (tx_q[s].size() != 0);
            source_beat[s] = (tx_q[s].size() != 0) ? {tx_q[s][0], 2'b00} : '0;
        end
        sink_ready = backpressure ? NK'($random(seed)) : '1;
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        fire = source_valid & source_ready;
        if (!rst) begin
            if ($countones(sink_valid) > `ROUTER_LANES) begin
                $display("more sinks active than lanes, sink_valid = %h", sink_valid);
                errors++;
            end
            for (int k = 0; k < NK; k++) begin
                if (stalled[k] && (!sink_valid[k] || sink_beat[k] != held[k])) begin
                    $display("** Error: sink_beat[%0d] = %h, expected %h held until taken",
                             k, sink_beat[k], held[k]);
                    errors++;
                end
                stalled[k] = sink_valid[k] && !sink_ready[k];
                held[k] = sink_beat[k];
                if (sink_valid[k] && sink_ready[k]) begin
                    check_beat(k);
                end
            end
        end
    end

    always @(negedge clk) begin
        cycles++;
        if (cycles > 20 * total_beats + 2000) begin
            $display("timeout after %0d cycles, traffic or APB write stuck", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int k;
        seed = 32'h6dd7;
        psel = 1'b1;     // write access held while reset is asserted
        penable = 1'b1;
        pwrite = 1'b1;
        paddr = '0;
        pwdata = '0;
        source_valid = '0;
        sink_ready = '1;
        backpressure = 1'b0;
        fire = '0;
        stalled = '0;
        errors = 0;
        test_errs = 0;
        tests = 0;
        tests_failed = 0;
        cycles = 0;
        total_beats = 0;
        for (int s = 0; s < NS; s++) begin
            source_beat[s] = '0;
        end
        for (int i = 0; i < NK; i++) begin
            pkt_src[i] = -1;
        end

        @(negedge clk);
        if (pready !== 1'b0) begin
            $display("** Error: pready = %h, expected 0 in reset", pready);
            errors++;
        end
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        while (rst) @(negedge clk);
        if (pready !== 1'b0 || sink_valid !== '0 || source_ready !== '1) begin
            $display("** Error: pready/sink_valid/source_ready = %h/%h/%h, expected 0/0/%h",
                     pready, sink_valid, source_ready, {NS{1'b1}});
            errors++;
        end
        apb_probe(8'h00, 1'b0);  // read returns zero
        apb_probe(8'h40, 1'b1);  // unmapped write
        end_test("reset state");

        k = $unsigned($random(seed)) % NK;
        apb_start(0, k);
        apb_finish(0, k);
        add_packet(0);
        wait_drain();
        end_test("single route");

        random_traffic(12);
        wait_drain();
        end_test("order and no interleave");

        k = $unsigned($random(seed)) % NK;
        for (int s = 0; s < NS; s++) begin
            apb_start(s, (s + k) % NK);
            apb_finish(s, (s + k) % NK);
        end
        for (int s = 0; s < NS; s++) begin
            add_packet(s);  // all four request together
        end
        wait_drain();
        end_test("lane contention");

        backpressure = 1'b1;
        random_traffic(12);
        wait_drain();
        backpressure = 1'b0;
        end_test("back-pressure");

        for (int i = 0; i < 3; i++) begin
            apb_start(NS - 1, i);
            apb_finish(NS - 1, i);
        end
        k = $unsigned($random(seed)) % NK;
        apb_start(NS - 1, k);
        repeat (8) begin
            @(negedge clk);
            if (pready) begin
                $display("APB write completed with three commands pending");
                errors++;
            end
        end
        add_packet(NS - 1);  // first packet frees a command slot
        apb_finish(NS - 1, k);
        repeat (3) add_packet(NS - 1);
        wait_drain();
        end_test("command FIFO full");

        $display("%0d tests, %0d failed, %0d errors", tests, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* bench/router_chk.sv */
`timescale 1ns/100ps
`include "router_consts.svh"

module router_chk (
    input logic clk,
    input logic rst,
    input logic pready,
    input logic [`ROUTER_SOURCES-1:0] arb_req,
    input logic [`ROUTER_LANES-1:0] lane_busy,
    input logic [`ROUTER_SINKS-1:0] sink_free,
    input router_pkg::grant_t grant
);

    logic [`ROUTER_SOURCES-1:0] req_q;  // requests seen by the arbiter last cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= '0;
        end else begin
            req_q <= arb_req;
        end
    end

    // each busy lane and a pending grant claim a sink of their own
    a_no_shared_sink: assert property (@(posedge clk) disable iff (rst)
        $countones(~sink_free) == $countones(lane_busy) + int'(grant.valid))
        else $error("two busy lanes target the same sink");

    a_pready_reset: assert property (@(posedge clk) rst |-> !pready)
        else $error("pready high during reset");

    a_grant_requested: assert property (@(posedge clk) disable iff (rst)
        grant.valid |-> req_q[grant.src])
        else $error("grant given to a source that did not request");

endmodule

bind router_channel_top router_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .pready    (pready),
    .arb_req   (arb_req),
    .lane_busy (lane_busy),
    .sink_free (sink_free),
    .grant     (grant)
);

/* bench/router_clkgen.sv */
`timescale 1ns/100ps

module router_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* rtl/router_channel_top.sv */
`timescale 1ns/100ps
`include "router_consts.svh"

module router_channel_top (
    input  logic clk,
    input  logic rst,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [7:0] paddr,
    input  logic [31:0] pwdata,
    output logic pready,
    output logic [31:0] prdata,
    output logic pslverr,
    input  logic [`ROUTER_SOURCES-1:0] source_valid,
    output logic [`ROUTER_SOURCES-1:0] source_ready,
    input  router_pkg::beat_t source_beat [`ROUTER_SOURCES],
    output logic [`ROUTER_SINKS-1:0] sink_valid,
    output router_pkg::beat_t sink_beat [`ROUTER_SINKS],
    input  logic [`ROUTER_SINKS-1:0] sink_ready
);

    router_pkg::cmd_t cmd;
    router_pkg::grant_t grant;
    router_pkg::sink_idx_t arb_req_sink [`ROUTER_SOURCES];
    router_pkg::sink_idx_t grant_sink;
    router_pkg::beat_t src_beat [`ROUTER_SOURCES];
    logic [`ROUTER_SOURCES-1:0] cmd_full;
    logic [`ROUTER_SOURCES-1:0] arb_req;
    logic [`ROUTER_SOURCES-1:0] src_valid;
    logic [`ROUTER_SOURCES-1:0] src_ready;
    logic [`ROUTER_LANES-1:0] lane_busy;
    logic [`ROUTER_SINKS-1:0] sink_free;

    router_apb_cmd u_apb (
        .clk (clk), .rst (rst),
        .psel (psel), .penable (penable), .pwrite (pwrite),
        .paddr (paddr), .pwdata (pwdata),
        .pready (pready), .prdata (prdata), .pslverr (pslverr),
        .cmd_full (cmd_full), .cmd (cmd)
    );

    for (genvar s = 0; s < `ROUTER_SOURCES; s++) begin : g_source
        router_channel_source #(.IDX(s)) u_source (
            .clk (clk), .rst (rst),
            .cmd (cmd), .cmd_full (cmd_full[s]),
            .source_valid (source_valid[s]), .source_ready (source_ready[s]),
            .source_beat (source_beat[s]), .sink_free (sink_free),
            .arb_req (arb_req[s]), .arb_req_sink (arb_req_sink[s]), .grant (grant),
            .lane_ready (src_ready[s]), .lane_valid (src_valid[s]), .lane_beat (src_beat[s])
        );
    end

    // winner's sink still at its command FIFO head
    assign grant_sink = arb_req_sink[grant.src];

    router_lane_arbiter u_arbiter (
        .clk (clk), .rst (rst),
        .arb_req (arb_req), .lane_busy (lane_busy), .grant (grant)
    );

    router_lane_crossbar u_crossbar (
        .clk (clk), .rst (rst),
        .grant (grant), .grant_sink (grant_sink),
        .src_valid (src_valid), .src_beat (src_beat), .src_ready (src_ready),
        .lane_busy (lane_busy), .sink_free (sink_free),
        .sink_valid (sink_valid), .sink_beat (sink_beat), .sink_ready (sink_ready)
    );

endmodule

/* rtl/router_lane_crossbar.sv */
`timescale 1ns/100ps
`include "router_consts.svh"

module router_lane_crossbar (
    input  logic clk,
    input  logic rst,
    input  router_pkg::grant_t grant,
    input  router_pkg::sink_idx_t grant_sink,
    input  logic [`ROUTER_SOURCES-1:0] src_valid,
    input  router_pkg::beat_t src_beat [`ROUTER_SOURCES],
    output logic [`ROUTER_SOURCES-1:0] src_ready,
    output logic [`ROUTER_LANES-1:0] lane_busy,
    output logic [`ROUTER_SINKS-1:0] sink_free,
    output logic [`ROUTER_SINKS-1:0] sink_valid,
    output router_pkg::beat_t sink_beat [`ROUTER_SINKS],
    input  logic [`ROUTER_SINKS-1:0] sink_ready
);

    router_pkg::source_idx_t lane_src [`ROUTER_LANES];
    router_pkg::sink_idx_t lane_sink [`ROUTER_LANES];
    logic [`ROUTER_LANES-1:0] lane_valid;
    logic [`ROUTER_LANES-1:0] lane_ready;
    logic [`ROUTER_LANES-1:0] lane_done;  // last beat accepted

    always_comb begin
        for (int l = 0; l < `ROUTER_LANES; l++) begin
            lane_valid[l] = lane_busy[l] && src_valid[lane_src[l]];
            lane_ready[l] = lane_busy[l] && sink_ready[lane_sink[l]];
            lane_done[l] = lane_valid[l] && lane_ready[l] && src_beat[lane_src[l]].last;
        end
    end

    always_comb begin
        src_ready = '0;
        sink_valid = '0;
        sink_free = '1;
        for (int k = 0; k < `ROUTER_SINKS; k++) begin
            sink_beat[k] = '0;
        end
        for (int l = 0; l < `ROUTER_LANES; l++) begin
            if (lane_busy[l]) begin
                src_ready[lane_src[l]] = lane_ready[l];
                sink_valid[lane_sink[l]] = lane_valid[l];
                sink_beat[lane_sink[l]] = src_beat[lane_src[l]];
                sink_free[lane_sink[l]] = 1'b0;
            end
        end
        if (grant.valid) begin
            sink_free[grant_sink] = 1'b0;  // claimed but not latched yet
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lane_busy <= '0;
        end else begin
            for (int l = 0; l < `ROUTER_LANES; l++) begin
                if (grant.valid && grant.lane == router_pkg::lane_idx_t'(l)) begin
                    lane_busy[l] <= 1'b1;
                end else if (lane_done[l]) begin
                    lane_busy[l] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant.valid) begin
            lane_src[grant.lane] <= grant.src;
            lane_sink[grant.lane] <= grant_sink;
        end
    end

endmodule

/* rtl/router_lane_arbiter.sv */
`timescale 1ns/100ps
`include "router_consts.svh"

module router_lane_arbiter (
    input  logic clk,
    input  logic rst,
    input  logic [`ROUTER_SOURCES-1:0] arb_req,
    input  logic [`ROUTER_LANES-1:0] lane_busy,
    output router_pkg::grant_t grant
);

    router_pkg::source_idx_t last_src;
    router_pkg::source_idx_t win_src;
    router_pkg::lane_idx_t free_lane;
    logic win_found;
    logic lane_found;
    logic [`ROUTER_LANES-1:0] lane_free;

    // lane granted last cycle is not busy in the crossbar yet
    always_comb begin
        lane_free = ~lane_busy;
        if (grant.valid) begin
            lane_free[grant.lane] = 1'b0;
        end
    end

    // lowest free lane
    always_comb begin
        lane_found = 1'b0;
        free_lane = '0;
        for (int l = 0; l < `ROUTER_LANES; l++) begin
            if (!lane_found && lane_free[l]) begin
                lane_found = 1'b1;
                free_lane = router_pkg::lane_idx_t'(l);
            end
        end
    end

    // round robin, search starts just after the previous winner
    always_comb begin
        int cand;
        win_found = 1'b0;
        win_src = last_src;
        for (int i = 1; i <= `ROUTER_SOURCES; i++) begin
            cand = (int'(last_src) + i) % `ROUTER_SOURCES;
            if (!win_found && arb_req[cand]) begin
                win_found = 1'b1;
                win_src = router_pkg::source_idx_t'(cand);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= '0;
            last_src <= router_pkg::source_idx_t'(`ROUTER_SOURCES - 1);  // source 0 first
        end else begin
            grant.valid <= win_found && lane_found;
            grant.src <= win_src;
            grant.lane <= free_lane;
            if (win_found && lane_found) begin
                last_src <= win_src;
            end
        end
    end

endmodule

/* rtl/router_channel_source.sv */
`timescale 1ns/100ps
`include "router_consts.svh"

module router_channel_source #(
    parameter int IDX = 0
) (
    input  logic clk,
    input  logic rst,
    input  router_pkg::cmd_t cmd,
    output logic cmd_full,
    input  logic source_valid,
    output logic source_ready,
    input  router_pkg::beat_t source_beat,
    input  logic [`ROUTER_SINKS-1:0] sink_free,
    output logic arb_req,
    output router_pkg::sink_idx_t arb_req_sink,
    input  router_pkg::grant_t grant,
    input  logic lane_ready,
    output logic lane_valid,
    output router_pkg::beat_t lane_beat
);

    logic cmd_push;
    logic cmd_empty;
    logic cmd_pop;
    logic own_grant;
    logic active;      // holding a lane
    logic req_mask;
    logic buf_ready;
    logic grant_clear;
    router_pkg::beat_t tagged_beat;

    assign cmd_push = cmd.valid && (cmd.src == router_pkg::source_idx_t'(IDX));
    assign own_grant = grant.valid && (grant.src == router_pkg::source_idx_t'(IDX));

    // full one early, the APB push lags by a cycle
    router_fifo #(
        .T      (router_pkg::sink_idx_t),
        .DEPTH  (`ROUTER_MOT),
        .ALMOST (1)
    ) u_cmd_fifo (
        .clk         (clk),
        .rst         (rst),
        .push        (cmd_push),
        .wr_data     (cmd.sink),
        .full        (),
        .almost_full (cmd_full),
        .pop         (cmd_pop),
        .rd_data     (arb_req_sink),
        .empty       (cmd_empty)
    );

    always_comb begin
        tagged_beat = source_beat;
        tagged_beat.src = router_pkg::source_idx_t'(IDX);  // stamp our index
    end

    generate
        if (`ROUTER_BUFFER != 0) begin : g_buffer
            logic buf_full;
            logic buf_empty;

            router_fifo #(
                .T      (router_pkg::beat_t),
                .DEPTH  (`ROUTER_BUF_DEPTH),
                .ALMOST (1)
            ) u_data_fifo (
                .clk         (clk),
                .rst         (rst),
                .push        (source_valid),
                .wr_data     (tagged_beat),
                .full        (buf_full),
                .almost_full (),
                .pop         (buf_ready),
                .rd_data     (lane_beat),
                .empty       (buf_empty)
            );

            assign source_ready = !buf_full;
            assign lane_valid = !buf_empty;
        end else begin : g_no_buffer
            assign source_ready = buf_ready;
            assign lane_valid = source_valid;
            assign lane_beat = tagged_beat;
        end
    endgenerate

    assign buf_ready = active && lane_ready;
    assign grant_clear = buf_ready && lane_valid && lane_beat.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            req_mask <= 1'b0;
            cmd_pop <= 1'b0;
        end else begin
            cmd_pop <= own_grant;   // head of command FIFO consumed a cycle later
            req_mask <= own_grant;  // stale sink at the head until that pop lands
            if (grant_clear) begin
                active <= 1'b0;
            end
            if (own_grant) begin
                active <= 1'b1;
            end
        end
    end

    // pending grant blocks a second request for the same packet
    assign arb_req = lane_valid
                   && (!active || grant_clear)
                   && !req_mask
                   && !own_grant
                   && !cmd_empty
                   && sink_free[arb_req_sink];

endmodule

/* rtl/router_apb_cmd.sv */
`timescale 1ns/100ps
`include "router_consts.svh"

module router_apb_cmd (
    input  logic clk,
    input  logic rst,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [7:0] paddr,
    input  logic [31:0] pwdata,
    output logic pready,
    output logic [31:0] prdata,
    output logic pslverr,
    input  logic [`ROUTER_SOURCES-1:0] cmd_full,
    output router_pkg::cmd_t cmd
);

    localparam int SB = $bits(router_pkg::source_idx_t);
    localparam int KB = $bits(router_pkg::sink_idx_t);

    router_pkg::source_idx_t addr_src;
    logic addr_hit;
    logic stall;
    logic push_now;

    // one word per source, 4*s
    assign addr_src = paddr[2 +: SB];
    assign addr_hit = (paddr[1:0] == 2'b00) && (paddr[7:2] < 6'(`ROUTER_SOURCES));

    assign stall = pwrite && addr_hit && cmd_full[addr_src];  // wait for room
    assign pready = psel && penable && !stall && !rst;  // no transfer completes in reset
    assign push_now = pready && pwrite && addr_hit;  // unmapped writes just complete

    assign prdata = '0;
    assign pslverr = 1'b0;

    // push leaves one cycle after the access completes
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd.valid <= 1'b0;
        end else begin
            cmd.valid <= push_now;
        end
    end

    always_ff @(posedge clk) begin
        if (push_now) begin
            cmd.src <= addr_src;
            cmd.sink <= pwdata[KB-1:0];
        end
    end

endmodule

/* rtl/router_fifo.sv */
`timescale 1ns/100ps

module router_fifo #(
    parameter type T = logic,
    parameter int DEPTH = 4,
    parameter int ALMOST = 1
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  T     wr_data,
    output logic full,
    output logic almost_full,
    input  logic pop,
    output T     rd_data,
    output logic empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic do_push;
    logic do_pop;

    assign do_push = push && !full;  // writes into a full FIFO are dropped
    assign do_pop = pop && !empty;

    assign full = (count == CW'(DEPTH));
    assign almost_full = (count >= CW'(DEPTH - ALMOST));
    assign empty = (count == '0);
    assign rd_data = mem[rd_ptr];  // first word falls through

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* rtl/router_pkg.sv */
`include "router_consts.svh"

package router_pkg;

    typedef logic [$clog2(`ROUTER_SOURCES)-1:0] source_idx_t;
    typedef logic [$clog2(`ROUTER_SINKS)-1:0] sink_idx_t;
    typedef logic [$clog2(`ROUTER_LANES)-1:0] lane_idx_t;

    // one data beat, tagged with the source it came from
    typedef struct packed {
        logic last;
        logic [`ROUTER_DATA-1:0] data;
        source_idx_t src;
    } beat_t;

    // command push from the APB side
    typedef struct packed {
        logic valid;
        source_idx_t src;
        sink_idx_t sink;
    } cmd_t;

    // registered arbiter decision, broadcast to all sources
    typedef struct packed {
        logic valid;
        source_idx_t src;
        lane_idx_t lane;
    } grant_t;

endpackage

/* rtl/router_consts.svh */
`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

// beat payload width
`define ROUTER_DATA 16

`define ROUTER_SOURCES 4
`define ROUTER_SINKS 4
`define ROUTER_LANES 2

// pending routing commands per source
`define ROUTER_MOT 4

// per-source data buffer
`define ROUTER_BUF_DEPTH 16
`define ROUTER_BUFFER 1

`endif
